// File: fault_detector_core.sv
// Fault detector core that checks one stream against a fast and a slow window
`timescale 1ns/1ps

module fault_detector_core (
    input  logic                                      clock,
    input  logic                                      rst_n,
    input  logic                                      stream_id,
    input  logic                                      sample_valid,
    input  logic [fmon_event_pkg::CHAN_W-1:0]         sample_channel,
    input  logic signed [fmon_event_pkg::SAMPLE_W-1:0] sample_data,
    input  logic signed [fmon_event_pkg::SAMPLE_W-1:0] fast_low,
    input  logic signed [fmon_event_pkg::SAMPLE_W-1:0] fast_high,
    input  logic signed [fmon_event_pkg::SAMPLE_W-1:0] slow_low,
    input  logic signed [fmon_event_pkg::SAMPLE_W-1:0] slow_high,
    input  logic [fmon_event_pkg::TRIP_W-1:0]         trip_duration,
    input  logic                                      clear_fault,
    input  logic                                      log_gnt,
    output logic                                      fast_fault,
    output logic                                      slow_fault,
    output logic                                      log_req,
    output fmon_event_pkg::fault_entry_t              log_entry
);
    import fmon_event_pkg::*;

    logic              fast_miss;
    logic              slow_miss;
    logic              slow_trip;
    logic [TRIP_W-1:0] run_cnt;
    logic [TRIP_W-1:0] run_next;
    logic [1:0]        new_kind;
    logic [1:0]        pending;
    logic [CHAN_W-1:0] evt_channel;
    logic signed [SAMPLE_W-1:0] evt_sample;

    // Window misses are signed compares against both bounds
    assign fast_miss = sample_valid && (sample_data < fast_low || sample_data > fast_high);
    assign slow_miss = sample_valid && (sample_data < slow_low || sample_data > slow_high);

    // Run length including the current miss, held at the top so it never wraps
    assign run_next = (run_cnt == '1) ? run_cnt : run_cnt + 1'b1;

    // A zero trip duration switches slow detection off
    assign slow_trip = slow_miss && (trip_duration != '0) && (run_next >= trip_duration);

    // Only a clear-to-set transition counts as a new event; a clear in the same cycle wins
    assign new_kind[0] = fast_miss && !fast_fault && !clear_fault;
    assign new_kind[1] = slow_trip && !slow_fault && !clear_fault;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            fast_fault <= 1'b0;
            slow_fault <= 1'b0;
            run_cnt <= '0;
        end else if (clear_fault) begin
            fast_fault <= 1'b0;
            slow_fault <= 1'b0;
            run_cnt <= '0;
        end else begin
            // Flags are sticky until software clears them
            fast_fault <= fast_fault | fast_miss;
            slow_fault <= slow_fault | slow_trip;
            if (slow_miss) begin
                run_cnt <= run_next;
            end else if (sample_valid) begin
                run_cnt <= '0;
            end
        end
    end

    // Pending kind bits survive a clear, later events are ORed in until the grant
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pending <= 2'b00;
        end else if (log_gnt) begin
            pending <= new_kind;
        end else begin
            pending <= pending | new_kind;
        end
    end

    // Payload is taken from the event that opens a request so the entry stays stable
    always_ff @(posedge clock) begin
        if (new_kind != 2'b00 && (pending == 2'b00 || log_gnt)) begin
            evt_channel <= sample_channel;
            evt_sample <= sample_data;
        end
    end

    assign log_req = |pending;

    always_comb begin
        log_entry = '0;
        log_entry.f.valid = 1'b1;
        log_entry.f.stream = stream_id;
        log_entry.f.kind = pending;
        log_entry.f.channel = evt_channel;
        log_entry.f.sample = evt_sample;
    end

endmodule

// File: fault_log_arbiter.sv
// Round-robin arbiter that puts one detector log request per cycle on the log port
`timescale 1ns/1ps

module fault_log_arbiter (
    input  logic                                   clock,
    input  logic                                   rst_n,
    input  logic [fmon_event_pkg::N_STREAMS-1:0]   req,
    input  fmon_event_pkg::fault_entry_t           entry [fmon_event_pkg::N_STREAMS],
    output logic [fmon_event_pkg::N_STREAMS-1:0]   gnt,
    output logic                                   log_wr,
    output fmon_event_pkg::fault_entry_t           log_wdata
);
    import fmon_event_pkg::*;

    logic [$clog2(N_STREAMS)-1:0] last_gnt;
    int                           sel;

    // Search starts one past the last winner so every requester gets a turn
    always_comb begin
        int idx;
        gnt = '0;
        log_wr = 1'b0;
        log_wdata = '0;
        sel = 0;
        for (int k = 0; k < N_STREAMS; k++) begin
            idx = (int'(last_gnt) + 1 + k) % N_STREAMS;
            if (!log_wr && req[idx]) begin
                gnt[idx] = 1'b1;
                log_wr = 1'b1;
                log_wdata = entry[idx];
                sel = idx;
            end
        end
    end

    // The pointer only moves on a grant
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            last_gnt <= '0;
        end else if (log_wr) begin
            last_gnt <= sel[$clog2(N_STREAMS)-1:0];
        end
    end

endmodule

// File: fault_log_fifo.sv
// Fault log FIFO with a head read port, a pop and a saturating drop counter
`timescale 1ns/1ps

module fault_log_fifo (
    input  logic                                  clock,
    input  logic                                  rst_n,
    input  logic                                  wr,
    input  fmon_event_pkg::fault_entry_t          wdata,
    input  logic                                  pop,
    input  logic                                  clear_drops,
    output fmon_event_pkg::fault_entry_t          head,
    output logic [fmon_event_pkg::LOG_AW:0]       count,
    output logic [fmon_event_pkg::DROP_W-1:0]     drops
);
    import fmon_event_pkg::*;

    fault_entry_t      mem [LOG_DEPTH];
    logic [LOG_AW-1:0] wr_ptr;
    logic [LOG_AW-1:0] rd_ptr;
    logic              full;
    logic              do_wr;
    logic              do_pop;

    assign full = (count == (LOG_AW + 1)'(LOG_DEPTH));
    assign do_wr = wr && !full;
    assign do_pop = pop && (count != '0);

    // Pointers wrap naturally since LOG_DEPTH is a power of two
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + do_wr - do_pop;
        end
    end

    always_ff @(posedge clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // Entries that find the log full are counted, the count sticks at its maximum
    always_ff @(posedge clock) begin
        if (!rst_n || clear_drops) begin
            drops <= '0;
        end else if (wr && full && drops != '1) begin
            drops <= drops + 1'b1;
        end
    end

    // An empty log shows an all-zero entry, so its valid bit reads low
    assign head = (count == '0) ? '0 : mem[rd_ptr];

endmodule

// File: fault_monitor.f
fmon_event_pkg.sv
fmon_reg_pkg.sv
fault_detector_core.sv
fault_log_arbiter.sv
fault_log_fifo.sv
fmon_apb_regs.sv
fault_monitor.sv
tb_fault_monitor.sv

// File: fault_monitor.sv
// Fault monitor top level joining the register block, detector cores, arbiter and log
`timescale 1ns/1ps

module fault_monitor (
    input  logic                                                             clock,
    input  logic                                                             rst_n,
    input  logic                                                             psel,
    input  logic                                                             penable,
    input  logic                                                             pwrite,
    input  logic [fmon_reg_pkg::APB_AW-1:0]                                  paddr,
    input  logic [fmon_reg_pkg::APB_DW-1:0]                                  pwdata,
    output logic [fmon_reg_pkg::APB_DW-1:0]                                  prdata,
    output logic                                                             pready,
    output logic                                                             pslverr,
    input  logic [fmon_event_pkg::N_STREAMS-1:0]                             sample_valid,
    input  logic [fmon_event_pkg::N_STREAMS-1:0][fmon_event_pkg::CHAN_W-1:0] sample_channel,
    input  logic [fmon_event_pkg::N_STREAMS-1:0][fmon_event_pkg::SAMPLE_W-1:0] sample_data,
    output logic                                                             fault
);
    import fmon_event_pkg::*;

    logic signed [SAMPLE_W-1:0] fast_low [N_STREAMS];
    logic signed [SAMPLE_W-1:0] fast_high [N_STREAMS];
    logic signed [SAMPLE_W-1:0] slow_low [N_STREAMS];
    logic signed [SAMPLE_W-1:0] slow_high [N_STREAMS];
    logic [TRIP_W-1:0]          trip_duration [N_STREAMS];
    logic [N_STREAMS-1:0]       fast_fault;
    logic [N_STREAMS-1:0]       slow_fault;
    logic [N_STREAMS-1:0]       log_req;
    logic [N_STREAMS-1:0]       log_gnt;
    fault_entry_t               log_entry [N_STREAMS];
    logic                       log_wr;
    fault_entry_t               log_wdata;
    fault_entry_t               log_head;
    logic [LOG_AW:0]            log_count;
    logic [DROP_W-1:0]          log_drops;
    logic                       clear_fault;
    logic                       log_pop;

    // One output summarises every sticky flag of every stream
    assign fault = |fast_fault || |slow_fault;

    fmon_apb_regs u_regs (
        .clock(clock), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .fast_low(fast_low), .fast_high(fast_high),
        .slow_low(slow_low), .slow_high(slow_high), .trip_duration(trip_duration),
        .fast_fault(fast_fault), .slow_fault(slow_fault),
        .log_head(log_head), .log_count(log_count), .log_drops(log_drops),
        .clear_fault(clear_fault), .log_pop(log_pop)
    );

    // One detector per stream, the stream index goes into each log entry
    for (genvar i = 0; i < N_STREAMS; i++) begin : g_core
        fault_detector_core u_core (
            .clock(clock), .rst_n(rst_n), .stream_id(1'(i)),
            .sample_valid(sample_valid[i]), .sample_channel(sample_channel[i]),
            .sample_data(sample_data[i]),
            .fast_low(fast_low[i]), .fast_high(fast_high[i]),
            .slow_low(slow_low[i]), .slow_high(slow_high[i]),
            .trip_duration(trip_duration[i]), .clear_fault(clear_fault),
            .log_gnt(log_gnt[i]), .fast_fault(fast_fault[i]), .slow_fault(slow_fault[i]),
            .log_req(log_req[i]), .log_entry(log_entry[i])
        );
    end

    fault_log_arbiter u_arbiter (
        .clock(clock), .rst_n(rst_n), .req(log_req), .entry(log_entry),
        .gnt(log_gnt), .log_wr(log_wr), .log_wdata(log_wdata)
    );

    // The CTRL clear also resets the drop count, the stored events stay
    fault_log_fifo u_log (
        .clock(clock), .rst_n(rst_n), .wr(log_wr), .wdata(log_wdata),
        .pop(log_pop), .clear_drops(clear_fault),
        .head(log_head), .count(log_count), .drops(log_drops)
    );

endmodule

// File: fmon_apb_regs.sv
// APB slave holding the window thresholds, fault status, clear control and log pop
`timescale 1ns/1ps

module fmon_apb_regs (
    input  logic                                       clock,
    input  logic                                       rst_n,
    input  logic                                       psel,
    input  logic                                       penable,
    input  logic                                       pwrite,
    input  logic [fmon_reg_pkg::APB_AW-1:0]            paddr,
    input  logic [fmon_reg_pkg::APB_DW-1:0]            pwdata,
    output logic [fmon_reg_pkg::APB_DW-1:0]            prdata,
    output logic                                       pready,
    output logic                                       pslverr,
    output logic signed [fmon_event_pkg::SAMPLE_W-1:0] fast_low [fmon_event_pkg::N_STREAMS],
    output logic signed [fmon_event_pkg::SAMPLE_W-1:0] fast_high [fmon_event_pkg::N_STREAMS],
    output logic signed [fmon_event_pkg::SAMPLE_W-1:0] slow_low [fmon_event_pkg::N_STREAMS],
    output logic signed [fmon_event_pkg::SAMPLE_W-1:0] slow_high [fmon_event_pkg::N_STREAMS],
    output logic [fmon_event_pkg::TRIP_W-1:0]          trip_duration [fmon_event_pkg::N_STREAMS],
    input  logic [fmon_event_pkg::N_STREAMS-1:0]       fast_fault,
    input  logic [fmon_event_pkg::N_STREAMS-1:0]       slow_fault,
    input  fmon_event_pkg::fault_entry_t               log_head,
    input  logic [fmon_event_pkg::LOG_AW:0]            log_count,
    input  logic [fmon_event_pkg::DROP_W-1:0]          log_drops,
    output logic                                       clear_fault,
    output logic                                       log_pop
);
    import fmon_reg_pkg::*;
    import fmon_event_pkg::*;

    logic              access;
    logic              hit;
    logic [APB_DW-1:0] rdata;

    // Address of one register inside the block of stream s
    function automatic logic [APB_AW-1:0] reg_addr(input int s, input int ofs);
        return APB_AW'(s * STREAM_STRIDE + ofs);
    endfunction

    // Thresholds read back sign-extended to the bus width
    function automatic logic [APB_DW-1:0] sext(input logic signed [SAMPLE_W-1:0] v);
        return {{(APB_DW - SAMPLE_W){v[SAMPLE_W-1]}}, v};
    endfunction

    // No wait states, every access completes in one cycle
    assign access = psel && penable;
    assign pready = 1'b1;

    // Address decode and read mux
    always_comb begin
        hit = 1'b0;
        rdata = '0;
        for (int s = 0; s < N_STREAMS; s++) begin
            if (paddr == reg_addr(s, SLOW_LOW_OFS)) begin
                hit = 1'b1;
                rdata = sext(slow_low[s]);
            end
            if (paddr == reg_addr(s, SLOW_HIGH_OFS)) begin
                hit = 1'b1;
                rdata = sext(slow_high[s]);
            end
            if (paddr == reg_addr(s, TRIP_DURATION_OFS)) begin
                hit = 1'b1;
                rdata = APB_DW'(trip_duration[s]);
            end
            if (paddr == reg_addr(s, FAST_LOW_OFS)) begin
                hit = 1'b1;
                rdata = sext(fast_low[s]);
            end
            if (paddr == reg_addr(s, FAST_HIGH_OFS)) begin
                hit = 1'b1;
                rdata = sext(fast_high[s]);
            end
        end
        if (paddr == STATUS_ADDR) begin
            hit = 1'b1;
            rdata[ST_FAST_LSB +: N_STREAMS] = fast_fault;
            rdata[ST_SLOW_LSB +: N_STREAMS] = slow_fault;
            rdata[ST_COUNT_LSB +: LOG_AW + 1] = log_count;
            rdata[ST_DROP_LSB +: DROP_W] = log_drops;
        end
        // CTRL is write only and reads back as zero
        if (paddr == CTRL_ADDR) begin
            hit = 1'b1;
        end
        if (paddr == LOG_ADDR) begin
            hit = 1'b1;
            rdata = log_head.raw;
        end
    end

    assign prdata = (access && !pwrite && hit) ? rdata : '0;
    assign pslverr = access && !hit;

    // Both pulses act on the clock edge that closes the access phase
    assign clear_fault = access && pwrite && (paddr == CTRL_ADDR) && pwdata[CTRL_CLEAR_BIT];
    assign log_pop = access && !pwrite && (paddr == LOG_ADDR) && (log_count != '0);

    // Configuration registers
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int s = 0; s < N_STREAMS; s++) begin
                fast_low[s] <= '0;
                fast_high[s] <= '0;
                slow_low[s] <= '0;
                slow_high[s] <= '0;
                trip_duration[s] <= '0;
            end
        end else if (access && pwrite) begin
            for (int s = 0; s < N_STREAMS; s++) begin
                if (paddr == reg_addr(s, SLOW_LOW_OFS)) slow_low[s] <= pwdata[SAMPLE_W-1:0];
                if (paddr == reg_addr(s, SLOW_HIGH_OFS)) slow_high[s] <= pwdata[SAMPLE_W-1:0];
                if (paddr == reg_addr(s, TRIP_DURATION_OFS)) begin
                    trip_duration[s] <= pwdata[TRIP_W-1:0];
                end
                if (paddr == reg_addr(s, FAST_LOW_OFS)) fast_low[s] <= pwdata[SAMPLE_W-1:0];
                if (paddr == reg_addr(s, FAST_HIGH_OFS)) fast_high[s] <= pwdata[SAMPLE_W-1:0];
            end
        end
    end

endmodule

// File: fmon_event_pkg.sv
// Fault event definitions shared by the detector cores, the arbiter and the log
package fmon_event_pkg;

    // Monitored streams and sample format
    localparam int N_STREAMS = 2;
    localparam int SAMPLE_W = 16;
    localparam int CHAN_W = 4;

    // Slow trip duration and drop counter widths
    localparam int TRIP_W = 8;
    localparam int DROP_W = 8;

    // Fault log geometry
    localparam int LOG_DEPTH = 16;
    localparam int LOG_AW = 4;

    // Kind codes, a fast and a slow event ORed together give KIND_BOTH
    localparam logic [1:0] KIND_FAST = 2'b01;
    localparam logic [1:0] KIND_SLOW = 2'b10;
    localparam logic [1:0] KIND_BOTH = 2'b11;

    // Field view of one log entry, from the top bit down
    typedef struct packed {
        logic                       valid;
        logic                       stream;
        logic [1:0]                 kind;
        logic [CHAN_W-1:0]          channel;
        logic [7:0]                 reserved;
        logic signed [SAMPLE_W-1:0] sample;
    } fault_fields_t;

    // The cores fill in fields while the APB side reads the same word raw
    typedef union packed {
        logic [31:0]   raw;
        fault_fields_t f;
    } fault_entry_t;

endpackage

// File: fmon_reg_pkg.sv
// Fault monitor register map, APB widths and STATUS field layout
package fmon_reg_pkg;

    // APB bus widths
    localparam int APB_AW = 8;
    localparam int APB_DW = 32;

    // Each stream owns a block of registers at STREAM_STRIDE times its index
    localparam int STREAM_STRIDE = 'h20;

    // Offsets inside one stream block
    localparam int SLOW_LOW_OFS = 'h00;
    localparam int SLOW_HIGH_OFS = 'h04;
    localparam int TRIP_DURATION_OFS = 'h08;
    localparam int FAST_LOW_OFS = 'h0C;
    localparam int FAST_HIGH_OFS = 'h10;

    // Shared registers above the stream blocks
    localparam logic [APB_AW-1:0] STATUS_ADDR = 8'h40;
    localparam logic [APB_AW-1:0] CTRL_ADDR = 8'h44;
    localparam logic [APB_AW-1:0] LOG_ADDR = 8'h48;

    // STATUS layout, each field starts at its LSB position
    localparam int ST_FAST_LSB = 0;
    localparam int ST_SLOW_LSB = 2;
    localparam int ST_COUNT_LSB = 8;
    localparam int ST_DROP_LSB = 16;

    // CTRL bit that clears the faults and the drop count
    localparam int CTRL_CLEAR_BIT = 0;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the fault monitor testbench with Verilator, runs it and checks for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fault_monitor -f fault_monitor.f -o sim_fault_monitor

output=$(./obj_dir/sim_fault_monitor)
echo "$output"

if grep -qF 'All tests passed!' <<< "$output"; then
    exit 0
fi
exit 1

// File: tb_fault_monitor.sv
// Testbench for the fault monitor covering registers, fast and slow faults, arbitration and the log
`timescale 1ns/1ps

module tb_fault_monitor;
    import fmon_reg_pkg::*;
    import fmon_event_pkg::*;

    // Status polls before a wait gives up
    localparam int WAIT_LIMIT = 40;

    logic                               clock;
    logic                               rst_n;
    logic                               psel;
    logic                               penable;
    logic                               pwrite;
    logic [APB_AW-1:0]                  paddr;
    logic [APB_DW-1:0]                  pwdata;
    logic [APB_DW-1:0]                  prdata;
    logic                               pready;
    logic                               pslverr;
    logic [N_STREAMS-1:0]               sample_valid;
    logic [N_STREAMS-1:0][CHAN_W-1:0]   sample_channel;
    logic [N_STREAMS-1:0][SAMPLE_W-1:0] sample_data;
    logic                               fault;

    // Fast window bounds as last written for the fault property
    int          fast_lo [N_STREAMS];
    int          fast_hi [N_STREAMS];
    // Register offsets of one stream block and the values written there
    int          offs [5];
    int          want [N_STREAMS][5];
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          errors_at_start;
    int          seed;
    logic [31:0] rd;
    logic        err;

    fault_monitor u_fault_monitor (
        .clock(clock), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .sample_valid(sample_valid), .sample_channel(sample_channel),
        .sample_data(sample_data), .fault(fault)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic note_mismatch(input string what);
        errors++;
        $display("Mismatch at %0t: %s", $time, what);
    endtask

    task automatic expect_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got == exp)
            else note_mismatch($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    // Address map with the stream blocks plus STATUS, CTRL and LOG
    function automatic logic is_mapped(input logic [APB_AW-1:0] addr);
        logic hit;
        hit = (addr == STATUS_ADDR) || (addr == CTRL_ADDR) || (addr == LOG_ADDR);
        for (int s = 0; s < N_STREAMS; s++) begin
            for (int k = 0; k < 5; k++) begin
                if (int'(addr) == s * STREAM_STRIDE + offs[k]) hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // Expected log word with the fields from the top bit down
    function automatic logic [31:0] make_entry(input int s, input logic [1:0] kind,
                                               input logic [3:0] ch, input int smp);
        return {1'b1, s[0], kind, ch, 8'h00, smp[15:0]};
    endfunction

    // Setup phase on one falling edge and access phase on the next
    task automatic write_reg(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
        @(negedge clock);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(negedge clock);
        penable = 1'b1;
        @(negedge clock);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    // Read data is sampled inside the access phase before the closing edge
    task automatic read_reg(input logic [APB_AW-1:0] addr, output logic [31:0] data,
                            output logic slverr);
        @(negedge clock);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = addr;
        @(negedge clock);
        penable = 1'b1;
        #1;
        data = prdata;
        slverr = pslverr;
        @(negedge clock);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic set_windows(input int s, input int slo, input int shi, input int trip,
                               input int flo, input int fhi);
        want[s] = '{slo, shi, trip, flo, fhi};
        fast_lo[s] = flo;
        fast_hi[s] = fhi;
        for (int k = 0; k < 5; k++) begin
            write_reg(8'(s * STREAM_STRIDE + offs[k]), 32'(want[s][k]));
        end
    endtask

    // One sample per selected stream that is valid for exactly one rising edge
    task automatic drive_samples(input logic [1:0] valid, input int d0, input int d1,
                                 input logic [3:0] ch);
        @(negedge clock);
        sample_valid = valid;
        sample_channel[0] = ch;
        sample_channel[1] = ch;
        sample_data[0] = SAMPLE_W'(d0);
        sample_data[1] = SAMPLE_W'(d1);
        @(negedge clock);
        sample_valid = '0;
    endtask

    task automatic wait_status(input logic [31:0] mask, input logic [31:0] value,
                               input string what);
        logic [31:0] st;
        logic        bad;
        int          tries;
        tries = 0;
        read_reg(STATUS_ADDR, st, bad);
        while ((st & mask) != value && tries < WAIT_LIMIT) begin
            read_reg(STATUS_ADDR, st, bad);
            tries++;
        end
        if ((st & mask) != value) begin
            errors++;
            $display("Timeout at %0t: STATUS never showed %s", $time, what);
        end
    endtask

    task automatic pop_expect(input logic [31:0] exp, input string what);
        logic [31:0] got;
        logic        bad;
        read_reg(LOG_ADDR, got, bad);
        expect_word(got, exp, what);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("Test %0d %s: PASS", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: FAIL", tests_run, name);
        end
        errors_at_start = errors;
    endtask

    // The slave never inserts wait states
    assert property (@(posedge clock) pready)
        else note_mismatch("pready low");

    // pslverr follows the address map and unmapped reads return zero
    assert property (@(posedge clock) disable iff (!rst_n)
        psel && penable |-> pslverr == !is_mapped(paddr))
        else note_mismatch("pslverr does not follow the address map");
    assert property (@(posedge clock) disable iff (!rst_n)
        psel && penable && !is_mapped(paddr) |-> prdata == '0)
        else note_mismatch("unmapped read returned data");

    assert property (@(posedge clock) !rst_n |=> !fault)
        else note_mismatch("fault high after reset");

    // A CTRL clear drops every flag by the next cycle
    assert property (@(posedge clock) disable iff (!rst_n)
        psel && penable && pwrite && paddr == CTRL_ADDR && pwdata[0] |=> !fault)
        else note_mismatch("fault still high after a clear");

    for (genvar s = 0; s < N_STREAMS; s++) begin : g_stream_chk
        // A fast window miss shows on fault one cycle later
        assert property (@(posedge clock) disable iff (!rst_n)
            sample_valid[s] && ($signed(sample_data[s]) < fast_lo[s] ||
            $signed(sample_data[s]) > fast_hi[s]) |=> fault)
            else note_mismatch($sformatf("fast miss on stream %0d left fault low", s));
        // With two peers a request that loses one round wins the next
        assert property (@(posedge clock) disable iff (!rst_n)
            u_fault_monitor.log_req[s] && !u_fault_monitor.log_gnt[s]
            |=> u_fault_monitor.log_gnt[s])
            else note_mismatch($sformatf("log request of stream %0d not granted", s));
    end

    initial begin
        logic [31:0] e0;
        logic [31:0] e1;
        logic [31:0] ea;
        logic [31:0] eb;
        seed = 32'hb0c4_478d;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        errors_at_start = 0;
        offs = '{SLOW_LOW_OFS, SLOW_HIGH_OFS, TRIP_DURATION_OFS, FAST_LOW_OFS, FAST_HIGH_OFS};
        rst_n = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        sample_valid = '0;
        sample_channel = '0;
        sample_data = '0;
        repeat (8) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;

        // Slightly different windows per stream so a crossed decode shows up
        for (int s = 0; s < N_STREAMS; s++) begin
            set_windows(s, -500 - s, 500 + s, 5 + s, -2000 - s, 2000 + s);
        end
        for (int s = 0; s < N_STREAMS; s++) begin
            for (int k = 0; k < 5; k++) begin
                read_reg(8'(s * STREAM_STRIDE + offs[k]), rd, err);
                expect_word({16'h0, rd[15:0]}, {16'h0, want[s][k][15:0]}, "register readback");
            end
        end
        read_reg(8'h14, rd, err);
        expect_word({31'h0, err}, 32'h1, "pslverr at 0x14");
        expect_word(rd, 32'h0, "read data at 0x14");
        write_reg(8'h4C, 32'hFFFF);
        end_test("register access");

        for (int i = 0; i < 20; i++) begin
            drive_samples(2'b11, $random(seed) % 400, $random(seed) % 400, 4'(i));
        end
        expect_word({31'h0, fault}, 32'h0, "fault after in-window samples");
        drive_samples(2'b10, 0, 2500, 4'h5);
        expect_word({31'h0, fault}, 32'h1, "fault after a fast miss");
        read_reg(STATUS_ADDR, rd, err);
        expect_word(rd & 32'hF, 32'h2, "STATUS flags after a fast miss");
        wait_status(32'h1F00, 32'h0100, "one logged event");
        pop_expect(make_entry(1, KIND_FAST, 4'h5, 2500), "fast event entry");
        write_reg(CTRL_ADDR, 32'h1);
        end_test("fast fault");

        // An in-window sample breaks the run before it reaches three
        write_reg(8'(TRIP_DURATION_OFS), 32'd3);
        drive_samples(2'b01, 600, 0, 4'h3);
        drive_samples(2'b01, 700, 0, 4'h3);
        drive_samples(2'b01, 0, 0, 4'h3);
        read_reg(STATUS_ADDR, rd, err);
        expect_word(rd & 32'hF, 32'h0, "STATUS flags after a broken run");
        drive_samples(2'b01, 600, 0, 4'h3);
        drive_samples(2'b01, 700, 0, 4'h3);
        drive_samples(2'b01, 800, 0, 4'h3);
        read_reg(STATUS_ADDR, rd, err);
        expect_word(rd & 32'hF, 32'h4, "STATUS flags after a full run");
        wait_status(32'h1F00, 32'h0100, "the slow event");
        pop_expect(make_entry(0, KIND_SLOW, 4'h3, 800), "slow event entry");
        write_reg(CTRL_ADDR, 32'h1);
        // The third miss is also beyond the fast window
        drive_samples(2'b01, 600, 0, 4'h6);
        drive_samples(2'b01, 700, 0, 4'h6);
        drive_samples(2'b01, 3000, 0, 4'h6);
        read_reg(STATUS_ADDR, rd, err);
        expect_word(rd & 32'hF, 32'h5, "STATUS flags after a double trip");
        wait_status(32'h1F00, 32'h0100, "the double trip event");
        pop_expect(make_entry(0, KIND_BOTH, 4'h6, 3000), "double trip entry");
        end_test("slow fault");

        write_reg(CTRL_ADDR, 32'h1);
        drive_samples(2'b11, 2500, -2500, 4'h9);
        read_reg(STATUS_ADDR, rd, err);
        expect_word(rd & 32'hF, 32'h3, "STATUS flags after a shared fault");
        wait_status(32'h1F00, 32'h0200, "two logged events");
        read_reg(LOG_ADDR, e0, err);
        read_reg(LOG_ADDR, e1, err);
        ea = make_entry(0, KIND_FAST, 4'h9, 2500);
        eb = make_entry(1, KIND_FAST, 4'h9, -2500);
        assert ((e0 == ea && e1 == eb) || (e0 == eb && e1 == ea))
            else note_mismatch($sformatf("arbitrated entries %h %h", e0, e1));
        end_test("arbitration");

        write_reg(CTRL_ADDR, 32'h1);
        expect_word({31'h0, fault}, 32'h0, "fault after a clear");
        read_reg(STATUS_ADDR, rd, err);
        expect_word(rd & 32'hF, 32'h0, "STATUS flags after a clear");
        write_reg(8'(TRIP_DURATION_OFS), 32'd0);
        write_reg(8'(STREAM_STRIDE + TRIP_DURATION_OFS), 32'd0);
        // Each clear re-arms the streams so every sample makes one event
        for (int i = 0; i < LOG_DEPTH; i++) begin
            write_reg(CTRL_ADDR, 32'h1);
            drive_samples(2'(1 << (i % 2)), 2100 + i, 2100 + i, 4'(i));
            wait_status(32'h1F00, 32'(i + 1) << 8, "the log filling up");
        end
        // Three more events without a clear all find the log full
        drive_samples(2'b01, 2200, 0, 4'hA);
        write_reg(8'(TRIP_DURATION_OFS), 32'd1);
        write_reg(8'(STREAM_STRIDE + TRIP_DURATION_OFS), 32'd1);
        drive_samples(2'b01, 800, 0, 4'hB);
        drive_samples(2'b10, 0, 800, 4'hC);
        wait_status(32'h00FF_1F00, 32'h0003_1000, "three drops with a full log");
        // A clear zeroes the drop count and keeps the stored events
        write_reg(CTRL_ADDR, 32'h1);
        read_reg(STATUS_ADDR, rd, err);
        expect_word(rd & 32'h00FF_1F00, 32'h0000_1000, "drops and log count after a clear");
        for (int i = 0; i < LOG_DEPTH; i++) begin
            pop_expect(make_entry(i % 2, KIND_FAST, 4'(i), 2100 + i), "log entry in order");
        end
        pop_expect(32'h0, "read of the empty log");
        end_test("clear and overflow");

        $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
